//--- Bender.yml
package:
  name: vdp_cmd_engine

sources:
  - vdp_cmd_pkg.sv
  - vdp_cmd_regs.sv
  - vdp_cmd_seq.sv
  - vdp_pixel_logic.sv
  - vdp_cmd_engine.sv
  - target: simulation
    files:
      - tb_vdp_cmd_engine.sv

//--- filelist.f
vdp_cmd_pkg.sv
vdp_cmd_regs.sv
vdp_cmd_seq.sv
vdp_pixel_logic.sv
vdp_cmd_engine.sv
tb_vdp_cmd_engine.sv

//--- tb_vdp_cmd_engine.sv
`timescale 1ns/1ps
/*
 * Testbench for the VDP drawing command engine
 * Replays the golden record file against the DUT with a randomly delayed
 * VRAM model, checks writes, CLR and memory, and stops on a watchdog
 */
module tb_vdp_cmd_engine;

  logic                      clk;
  logic                      reset;
  logic                      reg_wr_req;
  logic [3:0]                reg_num;
  logic [7:0]                reg_data;
  logic                      cmd_enable;
  vdp_cmd_pkg::screen_mode_t screen_mode;
  logic                      vram_rd_ack;
  logic                      vram_wr_ack;
  logic [7:0]                vram_rd_data;
  logic                      reg_wr_ack;
  logic                      vram_rd_req;
  logic                      vram_wr_req;
  vdp_cmd_pkg::vram_addr_t   vram_addr;
  logic [7:0]                vram_wr_data;
  logic [7:0]                clr;
  logic                      ce;
  logic [3:0]                current_command;

  logic [7:0] mem [0:131071];  // 128K VRAM
  int         wlog_addr [$];   // Writes seen in this test
  int         wlog_data [$];
  string      recs [$];
  int         seed = 19197;
  int         errors, checks, tests, failed_tests;
  int         ce_rises;
  logic       ce_prev;
  logic       rd_busy, wr_busy;
  int         rd_cnt, wr_cnt;

  vdp_cmd_engine i_vdp_cmd_engine (
    .clk, .reset, .reg_wr_req, .reg_num, .reg_data, .cmd_enable, .screen_mode,
    .vram_rd_ack, .vram_wr_ack, .vram_rd_data, .reg_wr_ack, .vram_rd_req,
    .vram_wr_req, .vram_addr, .vram_wr_data, .clr, .ce, .current_command
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // VRAM answers each toggle after 1 to 4 cycles
  always @(posedge clk) begin
    if (rd_busy) begin
      rd_cnt = rd_cnt - 1;
      if (rd_cnt == 0) begin
        vram_rd_data <= mem[vram_addr];
        vram_rd_ack  <= vram_rd_req;
        rd_busy = 1'b0;
      end
    end else if (vram_rd_req != vram_rd_ack) begin
      rd_busy = 1'b1;
      rd_cnt  = 1 + ($unsigned($random(seed)) % 4);
    end
    if (wr_busy) begin
      wr_cnt = wr_cnt - 1;
      if (wr_cnt == 0) begin
        mem[vram_addr] = vram_wr_data;
        wlog_addr.push_back(int'(vram_addr));
        wlog_data.push_back(int'(vram_wr_data));
        vram_wr_ack <= vram_wr_req;
        wr_busy = 1'b0;
      end
    end else if (vram_wr_req != vram_wr_ack) begin
      wr_busy = 1'b1;
      wr_cnt  = 1 + ($unsigned($random(seed)) % 4);
    end
  end

  // Count command starts seen on ce
  always @(posedge clk) begin
    ce_prev <= ce;
    if (ce && !ce_prev) begin
      ce_rises = ce_rises + 1;
    end
  end

  // Watchdog of 200 cycles per golden record
  initial begin
    wait (recs.size() != 0);
    repeat (recs.size() * 200) @(posedge clk);
    $display("watchdog expired after %0d cycles", recs.size() * 200);
    $display("TESTS FAILED");
    $finish;
  end

  // One CPU register write over the toggle handshake
  task automatic write_reg(input logic [3:0] num, input logic [7:0] data);
    @(posedge clk);
    reg_num    <= num;
    reg_data   <= data;
    reg_wr_req <= ~reg_wr_req;
    @(negedge clk);
    while (reg_wr_ack != reg_wr_req) @(negedge clk);
    @(negedge clk);  // Must not toggle again
    checks++;
    assert (reg_wr_ack == reg_wr_req) else begin
      $display("register R%0d was acknowledged more than once", num + 32);
      errors++;
    end
  endtask

  task automatic close_test(input string name, input int err_base);
    if (name.len() == 0) begin
      return;
    end
    tests++;
    if (errors == err_base) begin
      $display("test %s ok", name);
    end else begin
      $display("test %s %0d errors", name, errors - err_base);
      failed_tests++;
    end
  endtask

  initial begin
    int          fd;
    int          widx;
    int          err_base;
    string       line;
    string       name;
    byte         tag;
    logic [31:0] a, b;

    reset        = 1'b1;
    reg_wr_req   = 1'b0;
    reg_num      = 4'd0;
    reg_data     = 8'h00;
    cmd_enable   = 1'b1;
    screen_mode  = vdp_cmd_pkg::mode_g4;
    vram_rd_ack  = 1'b0;
    vram_wr_ack  = 1'b0;
    vram_rd_data = 8'h00;
    rd_busy      = 1'b0;
    wr_busy      = 1'b0;
    ce_rises     = 0;
    name         = "";
    for (int i = 0; i < 131072; i++) begin
      mem[i] = i[7:0] ^ i[15:8] ^ {i[16], 7'b0};  // Fill pattern from the whole address
    end

    fd = $fopen("vdp_cmd_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open the golden file");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0) begin
          while (line.len() > 0 && (line.getc(line.len() - 1) == 8'h0a ||
                                    line.getc(line.len() - 1) == 8'h0d)) begin
            line = line.substr(0, line.len() - 2);
          end
          if (line.len() > 0 && line.getc(0) != "#") begin
            recs.push_back(line);
          end
        end
      end
      $fclose(fd);
    end

    repeat (5) @(posedge clk);
    reset <= 1'b0;

    foreach (recs[r]) begin
      tag = recs[r].getc(0);
      a   = '0;
      b   = '0;
      if (recs[r].len() > 2 && tag != "T") begin
        void'($sscanf(recs[r].substr(2, recs[r].len() - 1), "%h %h", a, b));
      end
      case (tag)
        "T": begin
          close_test(name, err_base);
          name     = recs[r].substr(2, recs[r].len() - 1);
          err_base = errors;
          widx     = 0;
          ce_rises = 0;
          wlog_addr.delete();
          wlog_data.delete();
        end
        "M": begin
          @(posedge clk);
          screen_mode <= vdp_cmd_pkg::screen_mode_t'(a[1:0]);
        end
        "K": begin
          @(posedge clk);
          cmd_enable <= a[0];
        end
        "V": mem[a[16:0]] = b[7:0];  // Engine is idle here
        "R": begin
          write_reg(a[3:0], b[7:0]);
          if (a[3:0] == 4'd14) begin  // CMR opcode shows on current_command
            checks++;
            assert (current_command == b[7:4]) else begin
              $display("Mismatch current_command got %h exp %h", current_command, b[7:4]);
              errors++;
            end
          end
        end
        "G": begin
          @(negedge clk);
          while (ce) @(negedge clk);  // end of command
        end
        "E": begin
          checks++;
          if (widx >= wlog_addr.size()) begin
            assert (0) else begin
              $display("expected write %0d to %h never happened", widx, a);
              errors++;
            end
          end else begin
            assert (wlog_addr[widx] == a) else begin
              $display("Mismatch vram_addr got %h exp %h", wlog_addr[widx], a);
              errors++;
            end
            assert (wlog_data[widx] == b) else begin
              $display("Mismatch vram_wr_data got %h exp %h", wlog_data[widx], b);
              errors++;
            end
          end
          widx++;
        end
        "C": begin
          checks++;
          assert (clr == a[7:0]) else begin
            $display("Mismatch clr got %h exp %h", clr, a[7:0]);
            errors++;
          end
        end
        "X": begin
          checks++;
          assert (wlog_addr.size() == a) else begin
            $display("Mismatch write_count got %h exp %h", wlog_addr.size(), a);
            errors++;
          end
        end
        "Q": begin
          checks++;
          assert (mem[a[16:0]] == b[7:0]) else begin
            $display("Mismatch vram[%h] got %h exp %h", a[16:0], mem[a[16:0]], b[7:0]);
            errors++;
          end
        end
        "Z": begin
          checks++;
          assert (ce_rises == 0) else begin
            $display("a command started although the engine was disabled");
            errors++;
          end
        end
        default: begin
          $display("unknown golden record: %s", recs[r]);
          errors++;
        end
      endcase
    end
    close_test(name, err_base);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- vdp_cmd_engine.sv
`timescale 1ns/1ps
/*
 * VDP drawing command engine, top level
 * Register file, sequencer and pixel logic unit
 */
module vdp_cmd_engine (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      reg_wr_req,
  input  logic [3:0]                reg_num,
  input  logic [7:0]                reg_data,
  input  logic                      cmd_enable,
  input  vdp_cmd_pkg::screen_mode_t screen_mode,
  input  logic                      vram_rd_ack,
  input  logic                      vram_wr_ack,
  input  logic [7:0]                vram_rd_data,
  output logic                      reg_wr_ack,
  output logic                      vram_rd_req,
  output logic                      vram_wr_req,
  output vdp_cmd_pkg::vram_addr_t   vram_addr,
  output logic [7:0]                vram_wr_data,
  output logic [7:0]                clr,
  output logic                      ce,
  output logic [3:0]                current_command
);

  logic                cmd_start;
  vdp_cmd_pkg::coord_t sx, sy, dx, dy, nx, ny;
  logic                dix, diy;
  logic [7:0]          cmd;
  logic                point_load;
  logic [7:0]          point_color;
  logic [1:0]          x_low;
  logic [7:0]          rd_byte;
  logic [7:0]          merged_byte;

  assign current_command = cmd[7:4];  // CMR opcode field

  vdp_cmd_regs i_vdp_cmd_regs (
    .clk, .reset, .reg_wr_req, .reg_num, .reg_data, .cmd_enable, .screen_mode,
    .ce, .point_load, .point_color, .reg_wr_ack, .cmd_start,
    .sx, .sy, .dx, .dy, .nx, .ny, .dix, .diy, .cmd, .clr
  );

  vdp_cmd_seq i_vdp_cmd_seq (
    .clk, .reset, .cmd_start, .sx, .sy, .dx, .dy, .nx, .ny, .dix, .diy,
    .cmd, .clr, .screen_mode, .vram_rd_ack, .vram_wr_ack, .vram_rd_data,
    .merged_byte, .ce, .vram_rd_req, .vram_wr_req, .vram_addr, .vram_wr_data,
    .x_low, .rd_byte, .point_load
  );

  vdp_pixel_logic i_vdp_pixel_logic (
    .rd_byte, .x_low, .clr, .cmd, .screen_mode, .point_color, .merged_byte
  );

endmodule

//--- vdp_cmd_golden.txt
# T name | M mode | K enable | V addr data | R reg(0=R32) data | G run
# E addr data | C clr | X writes | Q addr data | Z no start
T regs
M 3
R 0 00
R 1 00
R 2 00
R 3 00
R 4 00
R 5 00
R 6 00
R 7 00
R 8 04
R 9 00
R a 01
R b 00
R c ab
R d 00
C ab
K 0
R e c0
G
X 0
Z
K 1
T hmmv_g4
M 0
R 4 0a
R 6 03
R 8 06
R a 02
R c 5a
R d 00
R e c0
G
E 185 5a
E 186 5a
E 187 5a
E 205 5a
E 206 5a
E 207 5a
X 6
T hmmv_g7_rev
M 3
R 4 14
R 6 05
R 8 03
R c c3
R d 0c
R e c0
G
E 514 c3
E 513 c3
E 512 c3
E 414 c3
E 413 c3
E 412 c3
X 6
T lmmv_g5
M 1
R 6 02
R a 01
R d 00
V 102 1b
R 4 08
R 8 04
R c 02
R e 80
G
R 8 01
V 103 ff
R 4 0d
R c 01
R e 81
G
V 104 00
R 4 12
R c 02
R e 82
G
V 105 55
R 4 17
R c 03
R e 83
G
V 106 3c
R 4 18
R c 01
R e 84
G
R 4 19
R c 04
R e 88
G
E 102 9b
E 102 ab
E 102 ab
E 102 aa
E 103 df
E 104 08
E 105 56
E 106 bc
E 106 bc
X 9
T pset_g6
M 2
V 110 7e
R 4 21
R 6 01
R c 09
R e 50
G
E 110 79
X 1
T point
M 0
V 102 c7
R 0 05
R 2 02
R e 40
G
C 07
M 1
V 83 e4
R 0 0e
R 2 01
R e 40
G
C 01
X 0
T clip_g7
M 3
R 4 fd
R 6 10
R 8 08
R a 02
R c 77
R e c0
G
E 10fd 77
E 10fe 77
E 10ff 77
E 11fd 77
E 11fe 77
E 11ff 77
X 6
T abort_g7
M 3
V 2040 66
R 4 00
R 6 20
R 8 40
R a 04
R c aa
R e c0
R c 55
R e c0
G
Q 2000 55
Q 201f 55
Q 233f 55
Q 2040 66

//--- vdp_cmd_pkg.sv
/*
 * VDP command engine shared definitions
 * Widths, command and logical-operation codes, the screen mode type,
 * the two-way view of a VRAM byte and the per-mode helper functions
 */
package vdp_cmd_pkg;

  localparam int coord_w = 10;  // X, Y and counts
  localparam int addr_w  = 17;  // 128K byte VRAM

  typedef logic [addr_w-1:0]  vram_addr_t;
  typedef logic [coord_w-1:0] coord_t;

  typedef enum logic [1:0] {
    mode_g4 = 2'd0,  // 256 wide, 4 bpp
    mode_g5 = 2'd1,  // 512 wide, 2 bpp
    mode_g6 = 2'd2,  // 512 wide, 4 bpp
    mode_g7 = 2'd3   // 256 wide, 8 bpp
  } screen_mode_t;

  // CMR[7:4] opcodes
  localparam logic [3:0] cmd_hmmv  = 4'b1100;  // Byte fill
  localparam logic [3:0] cmd_lmmv  = 4'b1000;  // Logical fill
  localparam logic [3:0] cmd_pset  = 4'b0101;
  localparam logic [3:0] cmd_point = 4'b0100;
  localparam logic [3:0] cmd_stop  = 4'b0000;

  // Logic op codes in CMR[2:0] with CMR[3] for transparency
  localparam logic [2:0] lop_imp = 3'b000;
  localparam logic [2:0] lop_and = 3'b001;
  localparam logic [2:0] lop_or  = 3'b010;
  localparam logic [2:0] lop_xor = 3'b011;
  localparam logic [2:0] lop_not = 3'b100;

  // Register numbers counted from R32
  localparam logic [3:0] reg_clr = 4'd12;  // R44
  localparam logic [3:0] reg_arg = 4'd13;  // R45
  localparam logic [3:0] reg_cmr = 4'd14;  // R46

  // One VRAM byte with the leftmost pixel always in the high bits
  typedef union packed {
    logic [1:0][3:0] nib;   // G4 and G6
    logic [3:0][1:0] dot2;  // G5
    logic [7:0]      raw;   // G7
  } pix_byte_u;

  // HMMV and the other high-speed moves work on whole bytes
  function automatic logic is_byte_cmd(input logic [7:0] cmr);
    return cmr[7:6] == 2'b11;
  endfunction

  // Bits of CLR that make up one pixel
  function automatic logic [7:0] col_mask(input screen_mode_t mode, input logic byte_op);
    if (byte_op) begin
      return 8'hff;
    end
    case (mode)
      mode_g4, mode_g6: return 8'h0f;
      mode_g5:          return 8'h03;
      default:          return 8'hff;
    endcase
  endfunction

  // Right screen edge or a wrap below zero
  function automatic logic x_limit_hit(input screen_mode_t mode, input coord_t x);
    case (mode)
      mode_g5, mode_g6: return x[9];         // 512 dots
      default:          return x[9] | x[8];  // 256 dots
    endcase
  endfunction

endpackage

//--- vdp_cmd_regs.sv
`timescale 1ns/1ps
/*
 * VDP command register file, R32 to R46
 * Takes CPU writes over the toggle handshake, splits them into byte lanes
 * and fires the command start on an accepted CMR write
 */
module vdp_cmd_regs (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      reg_wr_req,
  input  logic [3:0]                reg_num,
  input  logic [7:0]                reg_data,
  input  logic                      cmd_enable,
  input  vdp_cmd_pkg::screen_mode_t screen_mode,
  input  logic                      ce,
  input  logic                      point_load,
  input  logic [7:0]                point_color,
  output logic                      reg_wr_ack,
  output logic                      cmd_start,
  output vdp_cmd_pkg::coord_t       sx,
  output vdp_cmd_pkg::coord_t       sy,
  output vdp_cmd_pkg::coord_t       dx,
  output vdp_cmd_pkg::coord_t       dy,
  output vdp_cmd_pkg::coord_t       nx,
  output vdp_cmd_pkg::coord_t       ny,
  output logic                      dix,
  output logic                      diy,
  output logic [7:0]                cmd,
  output logic [7:0]                clr
);

  logic       wr_fire;   // pending CPU write
  logic       clr_wr;    // this write targets CLR
  logic [7:0] clr_mask;

  assign wr_fire  = (reg_wr_req != reg_wr_ack);
  assign clr_wr   = wr_fire && (reg_num == vdp_cmd_pkg::reg_clr);
  assign clr_mask = vdp_cmd_pkg::col_mask(screen_mode, vdp_cmd_pkg::is_byte_cmd(cmd));

  // Handshake, ARG, CMR and CLR
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reg_wr_ack <= 1'b0;
      cmd_start  <= 1'b0;
      dix        <= 1'b0;
      diy        <= 1'b0;
      cmd        <= 8'h00;
      clr        <= 8'h00;
    end else begin
      cmd_start <= 1'b0;  // single cycle pulse
      if (wr_fire) begin
        reg_wr_ack <= ~reg_wr_ack;
        case (reg_num)
          vdp_cmd_pkg::reg_arg: begin
            dix <= reg_data[2];
            diy <= reg_data[3];
          end
          vdp_cmd_pkg::reg_cmr: begin
            cmd       <= reg_data;
            cmd_start <= cmd_enable;  // restarts a running command too
          end
          default: ;
        endcase
      end
      if (clr_wr) begin
        // Running command only sees one pixel worth of colour
        clr <= ce ? (reg_data & clr_mask) : reg_data;
      end else if (point_load) begin
        clr <= point_color;  // POINT result
      end
    end
  end

  // Coordinate and size byte lanes
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      case (reg_num)
        4'd0:  sx[7:0] <= reg_data;       // R32
        4'd1:  sx[9:8] <= reg_data[1:0];  // R33
        4'd2:  sy[7:0] <= reg_data;       // R34
        4'd3:  sy[9:8] <= reg_data[1:0];  // R35
        4'd4:  dx[7:0] <= reg_data;       // R36
        4'd5:  dx[9:8] <= reg_data[1:0];  // R37
        4'd6:  dy[7:0] <= reg_data;       // R38
        4'd7:  dy[9:8] <= reg_data[1:0];  // R39
        4'd8:  nx[7:0] <= reg_data;       // R40
        4'd9:  nx[9:8] <= reg_data[1:0];  // R41
        4'd10: ny[7:0] <= reg_data;       // R42
        4'd11: ny[9:8] <= reg_data[1:0];  // R43
        default: ;
      endcase
    end
  end

endmodule

//--- vdp_cmd_seq.sv
`timescale 1ns/1ps
/*
 * VDP command sequencer
 * Steps X, Y and the counts of HMMV, LMMV, PSET and POINT, builds the
 * VRAM byte address per screen mode and drives the read and write toggles
 */
module vdp_cmd_seq (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      cmd_start,
  input  vdp_cmd_pkg::coord_t       sx,
  input  vdp_cmd_pkg::coord_t       sy,
  input  vdp_cmd_pkg::coord_t       dx,
  input  vdp_cmd_pkg::coord_t       dy,
  input  vdp_cmd_pkg::coord_t       nx,
  input  vdp_cmd_pkg::coord_t       ny,
  input  logic                      dix,
  input  logic                      diy,
  input  logic [7:0]                cmd,
  input  logic [7:0]                clr,
  input  vdp_cmd_pkg::screen_mode_t screen_mode,
  input  logic                      vram_rd_ack,
  input  logic                      vram_wr_ack,
  input  logic [7:0]                vram_rd_data,
  input  logic [7:0]                merged_byte,
  output logic                      ce,
  output logic                      vram_rd_req,
  output logic                      vram_wr_req,
  output vdp_cmd_pkg::vram_addr_t   vram_addr,
  output logic [7:0]                vram_wr_data,
  output logic [1:0]                x_low,
  output logic [7:0]                rd_byte,
  output logic                      point_load
);

  typedef enum logic [3:0] {
    st_idle, st_chk_loop, st_pre_rd, st_wait_pre_rd,
    st_wr, st_wait_wr, st_rd, st_wait_rd, st_end
  } state_t;

  state_t              state;
  vdp_cmd_pkg::coord_t x_w, y_w;    // Working DX and DY
  vdp_cmd_pkg::coord_t nx_w, ny_w;  // Remaining columns and rows
  vdp_cmd_pkg::coord_t nx_count;    // NX in steps
  vdp_cmd_pkg::coord_t x_step, y_step;
  logic                init_q;      // First pass through check-loop
  logic                byte_op;
  logic                row_end, area_end;
  logic                bus_idle;    // No VRAM transaction in flight
  logic [3:0]          op;

  assign op       = cmd[7:4];
  assign byte_op  = vdp_cmd_pkg::is_byte_cmd(cmd);
  assign bus_idle = (vram_rd_req == vram_rd_ack) && (vram_wr_req == vram_wr_ack);
  assign y_step   = diy ? '1 : vdp_cmd_pkg::coord_t'(1);
  assign area_end = (ny_w == vdp_cmd_pkg::coord_t'(1)) || (diy && (y_w == '0));

  // Byte commands move by whole bytes
  always_comb begin
    x_step   = vdp_cmd_pkg::coord_t'(1);
    nx_count = nx;
    if (byte_op) begin
      case (screen_mode)
        vdp_cmd_pkg::mode_g4, vdp_cmd_pkg::mode_g6: begin
          x_step   = vdp_cmd_pkg::coord_t'(2);
          nx_count = {1'b0, nx[9:1]};
        end
        vdp_cmd_pkg::mode_g5: begin
          x_step   = vdp_cmd_pkg::coord_t'(4);
          nx_count = {2'b00, nx[9:2]};
        end
        default: ;
      endcase
    end
    if (dix) begin
      x_step = -x_step;  // Leftwards
    end
  end

  always_comb begin
    case (op)
      vdp_cmd_pkg::cmd_hmmv, vdp_cmd_pkg::cmd_lmmv:
        row_end = (nx_w == '0) || vdp_cmd_pkg::x_limit_hit(screen_mode, x_w);
      default: row_end = 1'b1;  // single pixel commands
    endcase
  end

  // Byte address of pixel (x, y)
  function automatic vdp_cmd_pkg::vram_addr_t pix_addr(input vdp_cmd_pkg::screen_mode_t m,
                                                       input vdp_cmd_pkg::coord_t y,
                                                       input vdp_cmd_pkg::coord_t x);
    case (m)
      vdp_cmd_pkg::mode_g4: return {y[9:0], x[7:1]};  // 128 bytes a line
      vdp_cmd_pkg::mode_g5: return {y[9:0], x[8:2]};
      vdp_cmd_pkg::mode_g6: return {y[8:0], x[8:1]};  // 256 bytes a line
      default:              return {y[8:0], x[7:0]};
    endcase
  endfunction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state        <= st_idle;
      ce           <= 1'b0;
      init_q       <= 1'b0;
      point_load   <= 1'b0;
      vram_rd_req  <= 1'b0;
      vram_wr_req  <= 1'b0;
      vram_addr    <= '0;
      vram_wr_data <= 8'h00;
      x_low        <= 2'b00;
      rd_byte      <= 8'h00;
      x_w          <= '0;
      y_w          <= '0;
      nx_w         <= '0;
      ny_w         <= '0;
    end else begin
      point_load <= 1'b0;
      if (cmd_start) begin  // New command aborts the old one
        ce     <= 1'b1;
        init_q <= 1'b1;
        x_w    <= dx;
        y_w    <= dy;
        nx_w   <= nx_count;
        ny_w   <= ny;
        state  <= st_chk_loop;
      end else begin
        case (state)
          st_idle: ce <= 1'b0;
          st_chk_loop: begin
            init_q <= 1'b0;
            if (!init_q && row_end && area_end) begin
              state <= st_end;
            end else begin
              case (op)
                vdp_cmd_pkg::cmd_hmmv:  state <= st_wr;  // no read needed
                vdp_cmd_pkg::cmd_lmmv,
                vdp_cmd_pkg::cmd_pset:  state <= st_pre_rd;
                vdp_cmd_pkg::cmd_point: state <= st_rd;
                vdp_cmd_pkg::cmd_stop:  state <= st_end;
                default:                state <= st_end;
              endcase
            end
            if (!init_q && row_end) begin  // Next row
              x_w  <= dx;
              nx_w <= nx_count;
              ny_w <= ny_w - 1'b1;
              y_w  <= y_w + y_step;
            end
          end
          st_pre_rd: if (bus_idle) begin
            vram_addr   <= pix_addr(screen_mode, y_w, x_w);
            x_low       <= x_w[1:0];
            vram_rd_req <= ~vram_rd_ack;
            state       <= st_wait_pre_rd;
          end
          st_wait_pre_rd: if (vram_rd_req == vram_rd_ack) begin
            rd_byte <= vram_rd_data;  // Destination for the logic op
            state   <= st_wr;
          end
          st_wr: if (bus_idle) begin
            vram_addr    <= pix_addr(screen_mode, y_w, x_w);
            vram_wr_data <= byte_op ? clr : merged_byte;
            vram_wr_req  <= ~vram_wr_ack;
            state        <= st_wait_wr;
          end
          st_wait_wr: if (vram_wr_req == vram_wr_ack) begin
            if (op == vdp_cmd_pkg::cmd_pset) begin
              state <= st_end;
            end else begin
              x_w   <= x_w + x_step;
              nx_w  <= nx_w - 1'b1;
              state <= st_chk_loop;
            end
          end
          st_rd: if (bus_idle) begin  // POINT reads from SX, SY
            vram_addr   <= pix_addr(screen_mode, sy, sx);
            x_low       <= sx[1:0];
            vram_rd_req <= ~vram_rd_ack;
            state       <= st_wait_rd;
          end
          st_wait_rd: if (vram_rd_req == vram_rd_ack) begin
            rd_byte    <= vram_rd_data;
            point_load <= 1'b1;  // Pixel logic extracts it next cycle
            state      <= st_end;
          end
          st_end: begin
            ce    <= 1'b0;
            state <= st_idle;
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

endmodule

//--- vdp_pixel_logic.sv
`timescale 1ns/1ps
/*
 * VDP pixel logic unit
 * Picks the addressed pixel out of a VRAM byte, applies the logical
 * operation with CLR and merges the result back into the byte
 */
module vdp_pixel_logic (
  input  logic [7:0]                rd_byte,
  input  logic [1:0]                x_low,
  input  logic [7:0]                clr,
  input  logic [7:0]                cmd,
  input  vdp_cmd_pkg::screen_mode_t screen_mode,
  output logic [7:0]                point_color,
  output logic [7:0]                merged_byte
);

  vdp_cmd_pkg::pix_byte_u dst_u;   // Byte as read
  vdp_cmd_pkg::pix_byte_u out_u;   // Byte to write back
  logic [7:0]             mask;
  logic [7:0]             src_col; // CLR cut to pixel width
  logic [7:0]             lop_res;
  logic                   byte_op;
  logic                   nib_sel;
  logic [1:0]             dot_sel;

  assign byte_op = vdp_cmd_pkg::is_byte_cmd(cmd);
  assign mask    = vdp_cmd_pkg::col_mask(screen_mode, byte_op);
  assign src_col = clr & mask;
  assign dst_u   = rd_byte;
  assign nib_sel = ~x_low[0];  // Even X in the high nibble
  assign dot_sel = ~x_low;     // X mod 4 = 0 in bits 7:6

  // Addressed pixel right aligned
  always_comb begin
    if (byte_op) begin
      point_color = dst_u.raw;
    end else begin
      case (screen_mode)
        vdp_cmd_pkg::mode_g4,
        vdp_cmd_pkg::mode_g6: point_color = {4'h0, dst_u.nib[nib_sel]};
        vdp_cmd_pkg::mode_g5: point_color = {6'b000000, dst_u.dot2[dot_sel]};
        default:              point_color = dst_u.raw;
      endcase
    end
  end

  // Logical operation that keeps the destination on a transparent zero source
  always_comb begin
    lop_res = point_color;
    if (!(cmd[3] && (src_col == 8'h00))) begin
      case (cmd[2:0])
        vdp_cmd_pkg::lop_imp: lop_res = src_col;
        vdp_cmd_pkg::lop_and: lop_res = src_col & point_color;
        vdp_cmd_pkg::lop_or:  lop_res = src_col | point_color;
        vdp_cmd_pkg::lop_xor: lop_res = src_col ^ point_color;
        vdp_cmd_pkg::lop_not: lop_res = ~src_col & mask;
        default: ;  // undefined codes leave the pixel
      endcase
    end
  end

  // Put the pixel back with neighbours untouched
  always_comb begin
    out_u = dst_u;
    if (byte_op) begin
      out_u.raw = lop_res;
    end else begin
      case (screen_mode)
        vdp_cmd_pkg::mode_g4,
        vdp_cmd_pkg::mode_g6: out_u.nib[nib_sel]  = lop_res[3:0];
        vdp_cmd_pkg::mode_g5: out_u.dot2[dot_sel] = lop_res[1:0];
        default:              out_u.raw           = lop_res;
      endcase
    end
  end

  assign merged_byte = out_u.raw;

endmodule
